//--- exec_macros.svh
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// Integer datapath width
`define EXEC_XLEN 32

// Physical register file depth
`define EXEC_PREGS 64

// Physical register tag width, log2 of the register count
`define EXEC_PREG_W 6

// Reorder buffer tag width
`define EXEC_ROB_W 5

`endif

//--- rv32i_types.sv
`include "exec_macros.svh"

package rv32i_types;

    // ALU operations
    // Low three bits follow funct3, bit 3 marks sub and sra
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_e;

    // Branch conditions, encoded as the branch funct3
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_e;

    // Source of ALU operand A
    typedef enum logic [1:0] {
        op1_rs1 = 2'b00,
        op1_imm = 2'b01,
        op1_pc  = 2'b11
    } op1_sel_e;

    // Source of ALU operand B
    typedef enum logic [1:0] {
        op2_rs2  = 2'b00,
        op2_zero = 2'b01,
        op2_imm  = 2'b11
    } op2_sel_e;

    // Entry issued from the reservation station
    typedef struct packed {
        logic                     valid;
        logic [`EXEC_XLEN-1:0]    pc;
        logic [`EXEC_XLEN-1:0]    immediate;
        alu_op_e                  alu_op;
        cmp_op_e                  cmp_op;
        op1_sel_e                 op1_sel;
        op2_sel_e                 op2_sel;
        logic [`EXEC_PREG_W-1:0]  rs1_preg;
        logic [`EXEC_PREG_W-1:0]  rs2_preg;
        // Tag 0 means no register write
        logic [`EXEC_PREG_W-1:0]  rd_preg;
        logic [`EXEC_ROB_W-1:0]   rob_id;
    } fu_input_t;

    // Source operand values read from the register file
    typedef struct packed {
        logic [`EXEC_XLEN-1:0] rs1_value;
        logic [`EXEC_XLEN-1:0] rs2_value;
    } reg_response_t;

    // Result broadcast on the CDB
    typedef struct packed {
        logic                     valid;
        logic [`EXEC_ROB_W-1:0]   rob_id;
        logic [`EXEC_PREG_W-1:0]  rd_preg;
        logic [`EXEC_XLEN-1:0]    value;
        logic                     br_en;
    } fu_output_t;

endpackage : rv32i_types

//--- alu.sv
`timescale 1ns/1ns
`include "exec_macros.svh"

module alu (
    input  rv32i_types::alu_op_e  aluop,
    input  logic [`EXEC_XLEN-1:0] a,
    input  logic [`EXEC_XLEN-1:0] b,
    output logic [`EXEC_XLEN-1:0] f
);
    import rv32i_types::*;

    // Only the low five bits shift, as RV32I requires
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        unique case (aluop)
            alu_add:  f = a + b;
            alu_sub:  f = a - b;
            alu_sll:  f = a << shamt;
            // Set-less-than results are zero extended
            alu_slt:  f = {{(`EXEC_XLEN-1){1'b0}}, lt_signed};
            alu_sltu: f = {{(`EXEC_XLEN-1){1'b0}}, lt_unsigned};
            alu_xor:  f = a ^ b;
            alu_srl:  f = a >> shamt;
            // Arithmetic shift keeps the sign of a
            alu_sra:  f = $unsigned($signed(a) >>> shamt);
            alu_or:   f = a | b;
            alu_and:  f = a & b;
            default:  f = '0;
        endcase
    end

endmodule : alu

//--- cmp.sv
`timescale 1ns/1ns
`include "exec_macros.svh"

module cmp (
    input  rv32i_types::cmp_op_e  cmpop,
    input  logic [`EXEC_XLEN-1:0] a,
    input  logic [`EXEC_XLEN-1:0] b,
    output logic                  br_en
);
    import rv32i_types::*;

    // Shared compare terms
    logic eq;
    logic lt_signed;
    logic lt_unsigned;

    assign eq          = a == b;
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        unique case (cmpop)
            cmp_beq:  br_en = eq;
            cmp_bne:  br_en = ~eq;
            cmp_blt:  br_en = lt_signed;
            // Greater or equal is the inverse of less than
            cmp_bge:  br_en = ~lt_signed;
            cmp_bltu: br_en = lt_unsigned;
            cmp_bgeu: br_en = ~lt_unsigned;
            default:  br_en = 1'b0;
        endcase
    end

endmodule : cmp

//--- phys_regfile.sv
`timescale 1ns/1ns
`include "exec_macros.svh"

module phys_regfile (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [`EXEC_PREG_W-1:0]     rs1_preg,
    input  logic [`EXEC_PREG_W-1:0]     rs2_preg,
    output rv32i_types::reg_response_t  operands,
    input  logic                        wr_en,
    input  logic [`EXEC_PREG_W-1:0]     wr_preg,
    input  logic [`EXEC_XLEN-1:0]       wr_value
);
    import rv32i_types::*;

    // Physical register storage
    logic [`EXEC_XLEN-1:0] regs [`EXEC_PREGS];

    // One read port
    // Tag 0 reads zero, a same-cycle write is forwarded
    function automatic logic [`EXEC_XLEN-1:0] read_port(input logic [`EXEC_PREG_W-1:0] tag);
        logic [`EXEC_XLEN-1:0] value;
        if (tag == '0) begin
            value = '0;
        end else if (wr_en && (wr_preg == tag)) begin
            value = wr_value;
        end else begin
            value = regs[tag];
        end
        return value;
    endfunction

    // Writes arrive already qualified by the writeback stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `EXEC_PREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_preg] <= wr_value;
        end
    end

    // Combinational reads for both source operands
    always_comb begin
        operands.rs1_value = read_port(rs1_preg);
        operands.rs2_value = read_port(rs2_preg);
    end

endmodule : phys_regfile

//--- issue_stage.sv
`timescale 1ns/1ns
`include "exec_macros.svh"

module issue_stage (
    input  logic                        clk,
    input  logic                        arst_n,
    input  rv32i_types::fu_input_t      issue,
    output logic [`EXEC_PREG_W-1:0]     rs1_preg,
    output logic [`EXEC_PREG_W-1:0]     rs2_preg,
    input  rv32i_types::reg_response_t  operands,
    output rv32i_types::fu_input_t      ex_entry,
    output rv32i_types::reg_response_t  ex_operands
);
    import rv32i_types::*;

    // Execute stage valid, the only control bit here
    logic          ex_valid_q;
    // Captured entry and operand values
    fu_input_t     ex_entry_q;
    reg_response_t ex_operands_q;

    // Source tags go straight to the register file read ports
    assign rs1_preg = issue.rs1_preg;
    assign rs2_preg = issue.rs2_preg;

    // Valid loads every edge, so an idle issue cycle becomes a bubble
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid_q <= 1'b0;
        end else begin
            ex_valid_q <= issue.valid;
        end
    end

    // Payload is captured unconditionally, valid qualifies it downstream
    always_ff @(posedge clk) begin
        ex_entry_q    <= issue;
        ex_operands_q <= operands;
    end

    // Merge the reset valid into the registered entry
    always_comb begin
        ex_entry       = ex_entry_q;
        ex_entry.valid = ex_valid_q;
    end

    assign ex_operands = ex_operands_q;

endmodule : issue_stage

//--- fu_wrapper.sv
`timescale 1ns/1ns
`include "exec_macros.svh"

module fu_wrapper (
    // Entry in the execute stage
    input  rv32i_types::fu_input_t      to_be_calculated,
    // Its operand values, read at issue
    input  rv32i_types::reg_response_t  fu_reg_data,
    output rv32i_types::fu_output_t     fu_result
);
    import rv32i_types::*;

    // Operand usage by instruction type
    //   U-type  A = imm,  B = zero
    //   R-type  A = rs1,  B = rs2
    //   I-type  A = rs1,  B = imm
    //   B-type  A = pc,   B = imm, compare rs1 with rs2
    //   AUIPC   A = pc,   B = imm

    logic [`EXEC_XLEN-1:0] alu_input_a;
    logic [`EXEC_XLEN-1:0] alu_input_b;
    logic [`EXEC_XLEN-1:0] alu_value;
    logic                  cmp_value;

    // Operand A mux
    always_comb begin
        unique case (to_be_calculated.op1_sel)
            op1_rs1: alu_input_a = fu_reg_data.rs1_value;
            op1_imm: alu_input_a = to_be_calculated.immediate;
            op1_pc:  alu_input_a = to_be_calculated.pc;
            default: alu_input_a = '0;
        endcase
    end

    // Operand B mux
    always_comb begin
        unique case (to_be_calculated.op2_sel)
            op2_rs2:  alu_input_b = fu_reg_data.rs2_value;
            op2_zero: alu_input_b = '0;
            op2_imm:  alu_input_b = to_be_calculated.immediate;
            default:  alu_input_b = '0;
        endcase
    end

    alu calculator (
        .aluop (to_be_calculated.alu_op),
        .a     (alu_input_a),
        .b     (alu_input_b),
        .f     (alu_value)
    );

    // Comparator always sees the register values, independent of the muxes
    cmp comparator (
        .cmpop (to_be_calculated.cmp_op),
        .a     (fu_reg_data.rs1_value),
        .b     (fu_reg_data.rs2_value),
        .br_en (cmp_value)
    );

    // Pack the result
    // For a branch the ALU value is pc plus immediate, the target
    always_comb begin
        fu_result.valid   = to_be_calculated.valid;
        fu_result.rob_id  = to_be_calculated.rob_id;
        fu_result.rd_preg = to_be_calculated.rd_preg;
        fu_result.value   = alu_value;
        fu_result.br_en   = cmp_value;
    end

endmodule : fu_wrapper

//--- writeback_stage.sv
`timescale 1ns/1ns
`include "exec_macros.svh"

module writeback_stage (
    input  logic                     clk,
    input  logic                     arst_n,
    input  rv32i_types::fu_output_t  fu_result,
    output rv32i_types::fu_output_t  cdb,
    output logic                     wr_en,
    output logic [`EXEC_PREG_W-1:0]  wr_preg,
    output logic [`EXEC_XLEN-1:0]    wr_value
);
    import rv32i_types::*;

    // Broadcast valid, cleared by reset
    logic       cdb_valid_q;
    // Result payload
    fu_output_t cdb_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cdb_valid_q <= 1'b0;
        end else begin
            cdb_valid_q <= fu_result.valid;
        end
    end

    always_ff @(posedge clk) begin
        cdb_q <= fu_result;
    end

    // Registered result onto the CDB
    always_comb begin
        cdb       = cdb_q;
        cdb.valid = cdb_valid_q;
    end

    // Register write from the broadcast value
    // Tag 0 marks results with no destination, e.g. branches
    assign wr_en    = cdb_valid_q && (cdb_q.rd_preg != '0);
    assign wr_preg  = cdb_q.rd_preg;
    assign wr_value = cdb_q.value;

endmodule : writeback_stage

//--- exec_unit_top.sv
`timescale 1ns/1ns
`include "exec_macros.svh"

module exec_unit_top (
    input  logic                     clk,
    input  logic                     arst_n,
    // Issued entry, one per cycle at most
    input  rv32i_types::fu_input_t   issue,
    // Result broadcast, two cycles after issue
    output rv32i_types::fu_output_t  cdb
);
    import rv32i_types::*;

    // Register file read side
    logic [`EXEC_PREG_W-1:0] rs1_preg;
    logic [`EXEC_PREG_W-1:0] rs2_preg;
    reg_response_t           operands;

    // Execute stage
    fu_input_t               ex_entry;
    reg_response_t           ex_operands;
    fu_output_t              fu_result;

    // Register file write side
    logic                    wr_en;
    logic [`EXEC_PREG_W-1:0] wr_preg;
    logic [`EXEC_XLEN-1:0]   wr_value;

    issue_stage issue_stage0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue       (issue),
        .rs1_preg    (rs1_preg),
        .rs2_preg    (rs2_preg),
        .operands    (operands),
        .ex_entry    (ex_entry),
        .ex_operands (ex_operands)
    );

    phys_regfile phys_regfile0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_preg (rs1_preg),
        .rs2_preg (rs2_preg),
        .operands (operands),
        .wr_en    (wr_en),
        .wr_preg  (wr_preg),
        .wr_value (wr_value)
    );

    fu_wrapper fu_wrapper0 (
        .to_be_calculated (ex_entry),
        .fu_reg_data      (ex_operands),
        .fu_result        (fu_result)
    );

    writeback_stage writeback_stage0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .fu_result (fu_result),
        .cdb       (cdb),
        .wr_en     (wr_en),
        .wr_preg   (wr_preg),
        .wr_value  (wr_value)
    );

endmodule : exec_unit_top

//--- tb_exec_tasks.svh
`ifndef TB_EXEC_TASKS_SVH
`define TB_EXEC_TASKS_SVH

// Stop at the first error
task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped after an error");
endtask

// Wrong value on a named signal
task automatic report_mismatch(input string name, input logic [`EXEC_XLEN-1:0] expected,
                               input logic [`EXEC_XLEN-1:0] actual);
    stop_run($sformatf("** Error at %0t ns: %s expected 0x%08h, actual 0x%08h",
                       $time, name, expected, actual));
endtask

// Drive one entry for one cycle
// Called 1 ns after a rising edge, returns 1 ns after the next one
task automatic issue_entry(input fu_input_t entry);
    issue       = entry;
    issue.valid = 1'b1;
    @(posedge clk);
    #1;
    issue.valid = 1'b0;
endtask

// Wait for a broadcast, counting the edges passed
task automatic wait_cdb(output int waited);
    waited = 0;
    while (!cdb.valid) begin
        if (waited == 20) begin
            stop_run("Timeout: no broadcast on cdb within 20 cycles");
        end
        @(posedge clk);
        #1;
        waited++;
    end
endtask

// Idle cycles with nothing in flight
task automatic idle_cycles(input int count);
    for (int i = 0; i < count; i++) begin
        @(posedge clk);
        #1;
        if (cdb.valid !== 1'b0) begin
            stop_run("cdb.valid was high while no entry was in flight");
        end
    end
endtask

// Value, rob tag and destination tag of the current broadcast
task automatic check_value(input logic [`EXEC_XLEN-1:0]   exp_value,
                           input logic [`EXEC_ROB_W-1:0]  exp_rob,
                           input logic [`EXEC_PREG_W-1:0] exp_rd);
    if (cdb.value !== exp_value) begin
        report_mismatch("cdb.value", exp_value, cdb.value);
    end
    if (cdb.rob_id !== exp_rob) begin
        report_mismatch("cdb.rob_id", `EXEC_XLEN'(exp_rob), `EXEC_XLEN'(cdb.rob_id));
    end
    if (cdb.rd_preg !== exp_rd) begin
        report_mismatch("cdb.rd_preg", `EXEC_XLEN'(exp_rd), `EXEC_XLEN'(cdb.rd_preg));
    end
endtask

// Branch decision of the current broadcast
task automatic check_branch(input logic exp_br_en);
    if (cdb.br_en !== exp_br_en) begin
        report_mismatch("cdb.br_en", `EXEC_XLEN'(exp_br_en), `EXEC_XLEN'(cdb.br_en));
    end
endtask

`endif

//--- tb_exec_unit_top.sv
`timescale 1ns/1ns
`include "exec_macros.svh"

module tb_exec_unit_top;
    import rv32i_types::*;

    logic       clk;
    logic       arst_n;
    fu_input_t  issue;
    fu_output_t cdb;

    // Reference copy of the physical registers
    logic [`EXEC_XLEN-1:0]  model_regs [`EXEC_PREGS];
    // Operand source
    logic [31:0]            lfsr_state;
    // Next reorder buffer tag
    logic [`EXEC_ROB_W-1:0] next_rob;

    exec_unit_top dut0 (
        .clk    (clk),
        .arst_n (arst_n),
        .issue  (issue),
        .cdb    (cdb)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    `include "tb_exec_tasks.svh"

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] bits;
        logic        feedback;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            bits       = {bits[30:0], feedback};
        end
        return bits;
    endfunction

    // 12 bit immediate, sign extended as in I-type
    function automatic logic [31:0] random_imm12();
        logic [31:0] raw;
        raw = random_bits(12);
        return {{20{raw[11]}}, raw[11:0]};
    endfunction

    // New entry with the next rob tag
    function automatic fu_input_t build_entry(input alu_op_e op, input op1_sel_e sel_a,
                                              input op2_sel_e sel_b, input int rs1,
                                              input int rs2, input int rd,
                                              input logic [31:0] imm);
        fu_input_t entry;
        entry           = '0;
        entry.valid     = 1'b1;
        entry.alu_op    = op;
        entry.cmp_op    = cmp_beq;
        entry.op1_sel   = sel_a;
        entry.op2_sel   = sel_b;
        entry.rs1_preg  = `EXEC_PREG_W'(rs1);
        entry.rs2_preg  = `EXEC_PREG_W'(rs2);
        entry.rd_preg   = `EXEC_PREG_W'(rd);
        entry.immediate = imm;
        entry.rob_id    = next_rob;
        next_rob        = next_rob + 1'b1;
        return entry;
    endfunction

    // Expected value from the model registers under the RV32I rules
    function automatic logic [31:0] expected_result(input fu_input_t entry);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic [31:0] r;
        case (entry.op1_sel)
            op1_imm: a = entry.immediate;
            op1_pc:  a = entry.pc;
            default: a = model_regs[entry.rs1_preg];
        endcase
        case (entry.op2_sel)
            op2_zero: b = '0;
            op2_imm:  b = entry.immediate;
            default:  b = model_regs[entry.rs2_preg];
        endcase
        sh = b[4:0];
        case (entry.alu_op)
            alu_add:  r = a + b;
            // Two's complement subtraction
            alu_sub:  r = a + ~b + 32'd1;
            alu_sll:  r = a << sh;
            // Flipped sign bits turn the signed compare into an unsigned one
            alu_slt:  r = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            alu_sltu: r = (a < b) ? 32'd1 : 32'd0;
            alu_xor:  r = a ^ b;
            alu_srl:  r = a >> sh;
            // Logical shift then fill the vacated high bits with the sign
            alu_sra:  r = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            alu_or:   r = a | b;
            default:  r = a & b;
        endcase
        return r;
    endfunction

    // Branch condition rule
    function automatic logic expected_branch(input cmp_op_e op, input logic [31:0] a,
                                             input logic [31:0] b);
        logic lt_s;
        logic lt_u;
        logic taken;
        lt_u = a < b;
        lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
        case (op)
            cmp_beq:  taken = (a == b);
            cmp_bne:  taken = (a != b);
            cmp_blt:  taken = lt_s;
            cmp_bge:  taken = !lt_s;
            cmp_bltu: taken = lt_u;
            default:  taken = !lt_u;
        endcase
        return taken;
    endfunction

    // Issue, wait for the broadcast, check it and update the model
    task automatic execute_and_check(input fu_input_t entry);
        logic [31:0] expected;
        int          waited;
        expected = expected_result(entry);
        issue_entry(entry);
        wait_cdb(waited);
        // One edge after issue_entry returns is 2 cycles after the drive edge
        if (waited != 1) begin
            stop_run("cdb.valid did not rise exactly 2 cycles after the issue edge");
        end
        check_value(expected, entry.rob_id, entry.rd_preg);
        if (entry.rd_preg != '0) begin
            model_regs[entry.rd_preg] = expected;
        end
    endtask

    // U-type style load, A = imm and B = zero
    task automatic load_register(input int rd, input logic [31:0] value);
        execute_and_check(build_entry(alu_add, op1_imm, op2_zero, 0, 0, rd, value));
    endtask

    task automatic test_reset_state();
        arst_n = 1'b0;
        idle_cycles(5);
        arst_n = 1'b1;
        idle_cycles(3);
    endtask

    task automatic test_immediate_loads();
        for (int i = 1; i <= 8; i++) begin
            load_register(i, random_bits(32));
        end
    endtask

    task automatic test_alu_ops();
        alu_op_e ops [10];
        ops = '{alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
                alu_xor, alu_srl, alu_sra, alu_or, alu_and};
        for (int i = 0; i < 10; i++) begin
            // Register and register
            execute_and_check(build_entry(ops[i], op1_rs1, op2_rs2,
                                          1 + i % 8, 1 + (i + 3) % 8, 16 + i, '0));
            // Register and immediate, reading the result just broadcast
            execute_and_check(build_entry(ops[i], op1_rs1, op2_imm,
                                          16 + i, 0, 26 + i, random_imm12()));
        end
    endtask

    task automatic test_branches();
        cmp_op_e     conds [6];
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] pc;
        fu_input_t   entry;
        conds = '{cmp_beq, cmp_bne, cmp_blt, cmp_bge, cmp_bltu, cmp_bgeu};
        // Equal pair
        first = random_bits(32);
        load_register(40, first);
        load_register(41, first);
        // 42 below 43 signed, above it unsigned
        first  = random_bits(32);
        second = random_bits(32);
        load_register(42, {1'b1, first[30:0]});
        load_register(43, {1'b0, second[30:0]});
        // 44 below 45 unsigned, above it signed
        first  = random_bits(32);
        second = random_bits(32);
        load_register(44, {1'b0, first[30:0]});
        load_register(45, {1'b1, second[30:0]});
        for (int p = 0; p < 3; p++) begin
            for (int c = 0; c < 6; c++) begin
                // Both operand orders
                for (int s = 0; s < 2; s++) begin
                    pc           = random_bits(30);
                    entry        = build_entry(alu_add, op1_pc, op2_imm, 40 + 2 * p + s,
                                               41 + 2 * p - s, 0, random_imm12() << 1);
                    entry.pc     = {pc[29:0], 2'b00};
                    entry.cmp_op = conds[c];
                    execute_and_check(entry);
                    check_branch(expected_branch(conds[c], model_regs[entry.rs1_preg],
                                                 model_regs[entry.rs2_preg]));
                end
            end
        end
        // Branches wrote nothing, register 0 still reads zero
        execute_and_check(build_entry(alu_or, op1_rs1, op2_rs2, 0, 0, 46, '0));
    endtask

    task automatic test_forwarding();
        // Consumer sampled on the edge that writes the producer
        load_register(60, random_bits(32));
        execute_and_check(build_entry(alu_add, op1_rs1, op2_zero, 60, 0, 61, '0));
        // Overwrite, then read through the rs2 port in the write cycle
        load_register(60, random_bits(32));
        execute_and_check(build_entry(alu_add, op1_rs1, op2_rs2, 0, 60, 62, '0));
        // Load to tag 0 is broadcast but never stored or forwarded
        load_register(0, random_bits(32));
        execute_and_check(build_entry(alu_or, op1_rs1, op2_rs2, 0, 0, 63, '0));
    endtask

    task automatic test_back_to_back();
        fu_input_t   entries [8];
        logic [31:0] expected [8];
        alu_op_e     ops [8];
        int          waited;
        ops = '{alu_add, alu_sub, alu_xor, alu_or, alu_and, alu_sll, alu_srl, alu_sra};
        // Sources 1 to 8, destinations 48 to 55, no entry depends on another
        for (int i = 0; i < 8; i++) begin
            entries[i]  = build_entry(ops[i], op1_rs1, op2_rs2, 1 + i, 8 - i, 48 + i, '0);
            expected[i] = expected_result(entries[i]);
        end
        idle_cycles(1);
        fork
            begin
                for (int i = 0; i < 8; i++) begin
                    issue_entry(entries[i]);
                end
            end
            begin
                wait_cdb(waited);
                for (int i = 0; i < 8; i++) begin
                    if (i > 0) begin
                        @(posedge clk);
                        #1;
                        if (!cdb.valid) begin
                            stop_run("Back-to-back broadcasts were not on consecutive cycles");
                        end
                    end
                    check_value(expected[i], entries[i].rob_id, entries[i].rd_preg);
                end
            end
        join
        for (int i = 0; i < 8; i++) begin
            model_regs[48 + i] = expected[i];
        end
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        issue       = '0;
        lfsr_state  = 32'he7a9_35be;
        next_rob    = '0;
        for (int i = 0; i < `EXEC_PREGS; i++) begin
            model_regs[i] = '0;
        end
        test_reset_state();
        test_immediate_loads();
        test_alu_ops();
        test_branches();
        test_forwarding();
        test_back_to_back();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule : tb_exec_unit_top

//--- exec_unit_top.f
+incdir+.
rv32i_types.sv
alu.sv
cmp.sv
phys_regfile.sv
issue_stage.sv
fu_wrapper.sv
writeback_stage.sv
exec_unit_top.sv
tb_exec_unit_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --timescale 1ns/1ns \
    -f exec_unit_top.f --top-module tb_exec_unit_top -Mdir "$build_dir"
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

"./$build_dir/Vtb_exec_unit_top" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

# The testbench prints its fail line before stopping
if grep -q "TEST RESULT: FAIL" "$log_file"; then
    echo "Simulation reported a failure, see $log_file"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
